// File: logic/attn_pkg.sv
////////////////////////////////////////////////////////////////////////////
// shared sizes and encodings for the Q x K^T score stage
// ACC_W must cover INNER_DIM products of two DATA_W signed values
////////////////////////////////////////////////////////////////////////////

package attn_pkg;

    localparam int DATA_W      = 8;                    // q and k element width
    localparam int NUM_Q       = 2;                    // query rows per block
    localparam int NUM_K       = 2;                    // key rows per block
    localparam int INNER_DIM   = 4;                    // beats per block
    localparam int ACC_W       = 18;
    localparam int SCALE_SHIFT = 4;                    // arithmetic, no rounding
    localparam int OUT_W       = 10;
    localparam int CNT_W       = $clog2(INNER_DIM);

    // saturation bounds of a signed OUT_W score
    localparam int SCORE_MAX = (2 ** (OUT_W - 1)) - 1;
    localparam int SCORE_MIN = -(2 ** (OUT_W - 1));

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_ACCUM = 2'd1,
        ST_SCALE = 2'd2,
        ST_DONE  = 2'd3
    } ctrl_state_e;

    typedef enum logic [1:0] {
        ACC_HOLD  = 2'd0,
        ACC_CLEAR = 2'd1,
        ACC_ADD   = 2'd2
    } acc_op_e;

endpackage

// File: logic/score_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// start is taken only in ST_IDLE, in_valid only in ST_ACCUM
// out_valid is a single cycle pulse and is not held
////////////////////////////////////////////////////////////////////////////

module score_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  logic                in_valid,
    input  logic                last_beat,
    output attn_pkg::acc_op_e   acc_op,
    output logic                cnt_clear,
    output logic                cnt_inc,
    output logic                scale_load,
    output logic                busy,
    output logic                out_valid
);

    import attn_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;

    ////////////////////////////////////////////////////////////////////////////
    // next state and per-cycle commands
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d    = state_q;
        acc_op     = ACC_HOLD;
        cnt_clear  = 1'b0;
        cnt_inc    = 1'b0;
        scale_load = 1'b0;

        unique case (state_q)
            ST_IDLE: begin
                if (start) begin
                    acc_op    = ACC_CLEAR;              // fresh block
                    cnt_clear = 1'b1;
                    state_d   = ST_ACCUM;
                end
            end
            ST_ACCUM: begin
                if (in_valid) begin
                    acc_op  = ACC_ADD;
                    cnt_inc = 1'b1;
                    if (last_beat) begin
                        state_d = ST_SCALE;             // acc final after this edge
                    end
                end
            end
            ST_SCALE: begin
                scale_load = 1'b1;
                state_d    = ST_DONE;
            end
            ST_DONE: begin
                state_d = ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // both decoded from the state register only
    assign busy      = (state_q != ST_IDLE);
    assign out_valid = (state_q == ST_DONE);

endmodule

// File: logic/beat_counter.sv
////////////////////////////////////////////////////////////////////////////
// counts accepted beats, wraps at 2**CNT_W
////////////////////////////////////////////////////////////////////////////

module beat_counter (
    input  logic clk,
    input  logic rst,
    input  logic cnt_clear,
    input  logic cnt_inc,
    output logic last_beat
);

    import attn_pkg::*;

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (cnt_clear) begin
            cnt <= '0;                                  // clear wins over inc
        end else if (cnt_inc) begin
            cnt <= cnt + 1'b1;
        end
    end

    // terminal count decode
    assign last_beat = (cnt == CNT_W'(INNER_DIM - 1));

endmodule

// File: logic/outer_mac_array.sv
////////////////////////////////////////////////////////////////////////////
// one signed accumulator per (q, k) pair, no overflow detection
////////////////////////////////////////////////////////////////////////////

module outer_mac_array (
    input  logic                                                    clk,
    input  logic                                                    rst,
    input  attn_pkg::acc_op_e                                       acc_op,
    input  logic [attn_pkg::NUM_Q-1:0][attn_pkg::DATA_W-1:0]        q_col,
    input  logic [attn_pkg::NUM_K-1:0][attn_pkg::DATA_W-1:0]        k_col,
    output logic [attn_pkg::NUM_Q-1:0][attn_pkg::NUM_K-1:0][attn_pkg::ACC_W-1:0] acc
);

    import attn_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // outer product grid
    ////////////////////////////////////////////////////////////////////////////

    for (genvar qi = 0; qi < NUM_Q; qi++) begin : g_row
        for (genvar ki = 0; ki < NUM_K; ki++) begin : g_col
            logic signed [2*DATA_W-1:0] prod;

            assign prod = $signed(q_col[qi]) * $signed(k_col[ki]);

            always_ff @(posedge clk) begin
                if (rst) begin
                    acc[qi][ki] <= '0;
                end else begin
                    unique case (acc_op)
                        ACC_CLEAR: begin
                            acc[qi][ki] <= '0;
                        end
                        ACC_ADD: begin
                            // prod sign-extended to ACC_W
                            acc[qi][ki] <= $signed(acc[qi][ki]) + ACC_W'(prod);
                        end
                        default: begin
                            acc[qi][ki] <= acc[qi][ki]; // hold
                        end
                    endcase
                end
            end
        end
    end

endmodule

// File: logic/score_scaler.sv
////////////////////////////////////////////////////////////////////////////
// shift rounds toward minus infinity, then clamps to signed OUT_W
////////////////////////////////////////////////////////////////////////////

module score_scaler (
    input  logic                                                         clk,
    input  logic                                                         rst,
    input  logic                                                         scale_load,
    input  logic [attn_pkg::NUM_Q-1:0][attn_pkg::NUM_K-1:0][attn_pkg::ACC_W-1:0] acc,
    output logic [attn_pkg::NUM_Q-1:0][attn_pkg::NUM_K-1:0][attn_pkg::OUT_W-1:0] score
);

    import attn_pkg::*;

    logic [NUM_Q-1:0][NUM_K-1:0][OUT_W-1:0] clamped;

    for (genvar qi = 0; qi < NUM_Q; qi++) begin : g_row
        for (genvar ki = 0; ki < NUM_K; ki++) begin : g_col
            logic signed [ACC_W-1:0] shifted;

            assign shifted = $signed(acc[qi][ki]) >>> SCALE_SHIFT;

            always_comb begin
                if (shifted > SCORE_MAX) begin
                    clamped[qi][ki] = OUT_W'(SCORE_MAX);
                end else if (shifted < SCORE_MIN) begin
                    clamped[qi][ki] = OUT_W'(SCORE_MIN);
                end else begin
                    clamped[qi][ki] = shifted[OUT_W-1:0];   // fits, just truncate
                end
            end
        end
    end

    // output block, held until the next load
    always_ff @(posedge clk) begin
        if (rst) begin
            score <= '0;
        end else if (scale_load) begin
            score <= clamped;
        end
    end

endmodule

// File: logic/attn_score_top.sv
////////////////////////////////////////////////////////////////////////////
// no back-pressure: in_valid beats must not be dropped by the source
// score is valid with out_valid and holds until the next block
////////////////////////////////////////////////////////////////////////////

module attn_score_top (
    input  logic                                                         clk,
    input  logic                                                         rst,
    input  logic                                                         start,
    input  logic                                                         in_valid,
    input  logic [attn_pkg::NUM_Q-1:0][attn_pkg::DATA_W-1:0]             q_col,
    input  logic [attn_pkg::NUM_K-1:0][attn_pkg::DATA_W-1:0]             k_col,
    output logic                                                         busy,
    output logic                                                         out_valid,
    output logic [attn_pkg::NUM_Q-1:0][attn_pkg::NUM_K-1:0][attn_pkg::OUT_W-1:0] score
);

    import attn_pkg::*;

    acc_op_e                                acc_op;
    logic                                   cnt_clear;
    logic                                   cnt_inc;
    logic                                   last_beat;
    logic                                   scale_load;
    logic [NUM_Q-1:0][NUM_K-1:0][ACC_W-1:0] acc;

    score_ctrl i_ctrl (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .in_valid   (in_valid),
        .last_beat  (last_beat),
        .acc_op     (acc_op),
        .cnt_clear  (cnt_clear),
        .cnt_inc    (cnt_inc),
        .scale_load (scale_load),
        .busy       (busy),
        .out_valid  (out_valid)
    );

    beat_counter i_cnt (
        .clk        (clk),
        .rst        (rst),
        .cnt_clear  (cnt_clear),
        .cnt_inc    (cnt_inc),
        .last_beat  (last_beat)
    );

    outer_mac_array i_mac (
        .clk        (clk),
        .rst        (rst),
        .acc_op     (acc_op),
        .q_col      (q_col),
        .k_col      (k_col),
        .acc        (acc)
    );

    score_scaler i_scale (
        .clk        (clk),
        .rst        (rst),
        .scale_load (scale_load),
        .acc        (acc),
        .score      (score)
    );

endmodule

// File: sim/attn_score_chk.sv
////////////////////////////////////////////////////////////////////////////
// control timing checks bound into attn_score_top, idle while rst is high
////////////////////////////////////////////////////////////////////////////

module attn_score_chk (
    input logic clk,
    input logic rst,
    input logic busy,
    input logic out_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    // done lasts exactly one cycle
    a_single_pulse: assert property (@(posedge clk) disable iff (rst)
        out_valid |=> !out_valid)
        else $error("out_valid high for two cycles in a row");

    a_valid_busy: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> busy)
        else $error("out_valid high while busy is low");

    // controller back in idle after done
    a_idle_after: assert property (@(posedge clk) disable iff (rst)
        out_valid |=> !busy)
        else $error("busy still high in the cycle after out_valid");

endmodule

bind attn_score_top attn_score_chk i_chk (
    .clk        (clk),
    .rst        (rst),
    .busy       (busy),
    .out_valid  (out_valid)
);

// File: sim/attn_score_tb.sv
////////////////////////////////////////////////////////////////////////////
// table-driven testbench for attn_score_top, expected scores from the rule
// set_beat assumes NUM_Q and NUM_K are both 2
////////////////////////////////////////////////////////////////////////////

module attn_score_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import attn_pkg::*;

    localparam int NUM_TESTS      = 8;
    localparam int NUM_DIRECTED   = 4;
    localparam int MAX_GAP        = 3;
    localparam int RESET_CYCLES   = 16;
    localparam int EXP_LAT        = 2;
    localparam int LAT_LIMIT      = 8;
    localparam int SAT_HI         = 511;
    localparam int SAT_LO         = -512;
    localparam int TIMEOUT_CYCLES =
        NUM_TESTS * (INNER_DIM + INNER_DIM * MAX_GAP + 4) + RESET_CYCLES + 40;

    logic                                   clk = 1'b0;
    logic                                   rst;
    logic                                   start;
    logic                                   in_valid;
    logic [NUM_Q-1:0][DATA_W-1:0]           q_col;
    logic [NUM_K-1:0][DATA_W-1:0]           k_col;
    logic                                   busy;
    logic                                   out_valid;
    logic [NUM_Q-1:0][NUM_K-1:0][OUT_W-1:0] score;

    // stimulus table
    string                    test_name [NUM_TESTS];
    logic signed [DATA_W-1:0] q_tab     [NUM_TESTS][INNER_DIM][NUM_Q];
    logic signed [DATA_W-1:0] k_tab     [NUM_TESTS][INNER_DIM][NUM_K];
    int                       gap_tab   [NUM_TESTS][INNER_DIM];
    bit                       extra_tab [NUM_TESTS];

    int     exp_score [NUM_Q][NUM_K];
    integer seed;
    int     test_errs;
    int     err_count;
    int     tests_run;
    int     fail_tests;
    int     ov_count  = 0;
    int     cycle_cnt = 0;

    attn_score_top i_dut (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .in_valid   (in_valid),
        .q_col      (q_col),
        .k_col      (k_col),
        .busy       (busy),
        .out_valid  (out_valid),
        .score      (score)
    );

    always #10 clk = ~clk;                              // 20 ns period

    always @(negedge clk) begin
        if (!rst && out_valid) begin
            ov_count <= ov_count + 1;                   // done pulses seen
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // table setup and reference model
    ////////////////////////////////////////////////////////////////////////////

    task automatic set_beat(input int t, input int b, input int q0, input int q1,
                            input int k0, input int k1, input int gap);
        q_tab[t][b][0] = DATA_W'(q0);
        q_tab[t][b][1] = DATA_W'(q1);
        k_tab[t][b][0] = DATA_W'(k0);
        k_tab[t][b][1] = DATA_W'(k1);
        gap_tab[t][b]  = gap;
    endtask

    task automatic build_table();
        test_name = '{"small_pos", "neg_shift", "saturate", "gaps_restart",
                      "", "", "", ""};
        set_beat(0, 0, 2, 3, 4, 5, 0);
        set_beat(0, 1, 1, 2, 3, 1, 0);
        set_beat(0, 2, 4, 1, 2, 2, 0);
        set_beat(0, 3, 3, 3, 1, 6, 0);
        set_beat(1, 0, -5, 3, 4, -1, 0);               // -20 >>> 4 is -2
        for (int b = 1; b < INNER_DIM; b++) begin
            set_beat(1, b, 0, 0, 0, 0, 0);
            set_beat(2, b, 127, -128, 127, 127, 0);
        end
        set_beat(2, 0, 127, -128, 127, 127, 0);
        set_beat(3, 0, 10, -7, 6, 3, 2);
        set_beat(3, 1, -12, 9, 5, -8, 0);
        set_beat(3, 2, 30, 4, -2, 11, 3);
        set_beat(3, 3, 7, -20, 9, 1, 1);
        for (int t = 0; t < NUM_TESTS; t++) begin
            extra_tab[t] = (t == 3);
        end
        for (int t = NUM_DIRECTED; t < NUM_TESTS; t++) begin
            test_name[t] = $sformatf("random_%0d", t - NUM_DIRECTED);
            for (int b = 0; b < INNER_DIM; b++) begin
                set_beat(t, b, $random(seed), $random(seed), $random(seed),
                         $random(seed), 0);
            end
        end
    endtask

    task automatic compute_expected(input int t);
        int sum;
        for (int qi = 0; qi < NUM_Q; qi++) begin
            for (int ki = 0; ki < NUM_K; ki++) begin
                sum = 0;
                for (int b = 0; b < INNER_DIM; b++) begin
                    sum += int'(q_tab[t][b][qi]) * int'(k_tab[t][b][ki]);
                end
                sum = sum >>> SCALE_SHIFT;              // floor toward -inf
                if (sum > SAT_HI) begin
                    sum = SAT_HI;
                end else if (sum < SAT_LO) begin
                    sum = SAT_LO;
                end
                exp_score[qi][ki] = sum;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // checks and test sequencing
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_score(input int t, input string what);
        int act;
        for (int qi = 0; qi < NUM_Q; qi++) begin
            for (int ki = 0; ki < NUM_K; ki++) begin
                act = int'($signed(score[qi][ki]));
                if (act != exp_score[qi][ki]) begin
                    $display("mismatch %s %s[%0d][%0d] expected %0d actual %0d",
                             test_name[t], what, qi, ki, exp_score[qi][ki], act);
                    test_errs++;
                end
            end
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        err_count += test_errs;
        if (test_errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: failed with %0d errors", name, test_errs);
            fail_tests++;
        end
    endtask

    task automatic run_test(input int t);
        int lat;
        int ov_base;
        test_errs = 0;
        @(posedge clk);
        start   <= 1'b1;
        ov_base = ov_count;
        @(posedge clk);
        start <= 1'b0;
        for (int b = 0; b < INNER_DIM; b++) begin
            for (int g = 0; g < gap_tab[t][b]; g++) begin
                in_valid <= 1'b0;
                start    <= extra_tab[t] && (g == 0);   // stray start while busy
                @(posedge clk);
            end
            in_valid <= 1'b1;
            start    <= 1'b0;
            for (int qi = 0; qi < NUM_Q; qi++) begin
                q_col[qi] <= q_tab[t][b][qi];
            end
            for (int ki = 0; ki < NUM_K; ki++) begin
                k_col[ki] <= k_tab[t][b][ki];
            end
            @(posedge clk);
        end
        in_valid <= 1'b0;
        lat = 1;                                        // from the edge presenting the last beat
        @(negedge clk);
        check_score(t, "held_score");                   // previous block while acc is new
        if (!busy) begin
            $display("%s: busy low while the block is still in progress", test_name[t]);
            test_errs++;
        end
        compute_expected(t);
        while (!out_valid && lat < LAT_LIMIT) begin
            @(posedge clk);
            lat++;
            @(negedge clk);
        end
        if (!out_valid) begin
            $display("%s: out_valid never arrived after the last beat", test_name[t]);
            test_errs++;
        end else begin
            if (lat != EXP_LAT) begin
                $display("mismatch %s out_valid latency expected %0d actual %0d",
                         test_name[t], EXP_LAT, lat);
                test_errs++;
            end
            check_score(t, "score");
        end
        @(posedge clk);
        @(negedge clk);
        if (busy || out_valid) begin
            $display("%s: busy or out_valid still high after the done cycle", test_name[t]);
            test_errs++;
        end
        @(posedge clk);
        if (ov_count - ov_base != 1) begin
            $display("mismatch %s out_valid pulses expected 1 actual %0d",
                     test_name[t], ov_count - ov_base);
            test_errs++;
        end
        finish_test(test_name[t]);
    endtask

    initial begin
        seed       = 32'ha06b_d546;
        rst        = 1'b1;
        start      = 1'b0;
        in_valid   = 1'b0;
        q_col      = '0;
        k_col      = '0;
        err_count  = 0;
        tests_run  = 0;
        fail_tests = 0;
        build_table();
        for (int qi = 0; qi < NUM_Q; qi++) begin
            for (int ki = 0; ki < NUM_K; ki++) begin
                exp_score[qi][ki] = 0;                  // score after reset
            end
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        test_errs = 0;
        if (busy !== 1'b0 || out_valid !== 1'b0) begin
            $display("reset_state: busy or out_valid is not low after reset");
            test_errs++;
        end
        if (score !== '0) begin
            $display("mismatch reset_state score expected 0 actual %h", score);
            test_errs++;
        end
        finish_test("reset_state");
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);                                // back to back blocks
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - fail_tests, fail_tests, err_count);
        if (err_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: list.f
logic/attn_pkg.sv
logic/score_ctrl.sv
logic/beat_counter.sv
logic/outer_mac_array.sv
logic/score_scaler.sv
logic/attn_score_top.sv
sim/attn_score_chk.sv
sim/attn_score_tb.sv

// File: run.sh
#!/bin/sh
# builds the score stage testbench with Verilator and runs it
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal -f list.f \
        --top-module attn_score_tb -Mdir obj_dir \
    && ./obj_dir/Vattn_score_tb | tee /dev/stderr | grep -qx '=== PASS ===' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
